/* hdl/cache_pkg.sv */
package cache_pkg;

	// Width of a cache line address.
	localparam int ADDR_W = 32;

	// Occupancy field width, enough for the largest buffer of 128 slots.
	localparam int OCC_W = 8;

	// Width of the write-back counter.
	localparam int WB_CNT_W = 32;

	// Line address as it travels on the mark and write-back streams.
	typedef logic [ADDR_W-1:0] line_addr_t;

	// Write-back request handed to the memory side.
	typedef struct packed {
		line_addr_t addr;
	} wb_req_t;

	// Buffer status as seen by the controller and the register slave.
	typedef struct packed {
		logic             empty;
		logic             full;
		logic [OCC_W-1:0] occupancy;
	} status_t;

endpackage

/* hdl/axil_pkg.sv */
package axil_pkg;

	// Register bus address and data widths.
	localparam int AXIL_AW = 8;
	localparam int AXIL_DW = 32;

	// Response codes.
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// Register map.
	localparam logic [AXIL_AW-1:0] REG_CTRL   = 8'h00;
	localparam logic [AXIL_AW-1:0] REG_STATUS = 8'h04;
	localparam logic [AXIL_AW-1:0] REG_WBCNT  = 8'h08;

	// Master to slave.
	typedef struct packed {
		logic               awvalid;
		logic [AXIL_AW-1:0] awaddr;
		logic               wvalid;
		logic [AXIL_DW-1:0] wdata;
		logic               bready;
		logic               arvalid;
		logic [AXIL_AW-1:0] araddr;
		logic               rready;
	} axil_req_t;

	// Slave to master.
	typedef struct packed {
		logic               awready;
		logic               wready;
		logic               bvalid;
		logic [1:0]         bresp;
		logic               arready;
		logic               rvalid;
		logic [AXIL_DW-1:0] rdata;
		logic [1:0]         rresp;
	} axil_rsp_t;

endpackage

/* hdl/prio_enc.sv */
module prio_enc #(
	parameter int DP = 16
) (
	input  logic [DP-1:0]         in_i,
	output logic [$clog2(DP)-1:0] pos_o,
	output logic                  none_o
);

	localparam int CW = $clog2(DP);

	// Walk from the top bit down.
	// The last hit is the lowest set bit, so it wins.
	always_comb begin
		pos_o = '0;
		for (int i = DP - 1; i >= 0; i--) begin
			if (in_i[i]) begin
				pos_o = CW'(i);
			end
		end
	end

	// No bit set at all.
	// Position is then zero and must be ignored.
	assign none_o = ~|in_i;

endmodule

/* hdl/slot_store.sv */
module slot_store #(
	parameter int DP = 16
) (
	input  logic                  CLK,
	input  logic                  rst_n_i,
	input  logic                  wr_en_i,
	input  logic [$clog2(DP)-1:0] wr_idx_i,
	input  cache_pkg::line_addr_t wr_addr_i,
	input  logic                  clr_en_i,
	input  logic [$clog2(DP)-1:0] clr_idx_i,
	output logic [DP-1:0]         valid_o,
	output cache_pkg::line_addr_t addrs_o [DP]
);

	import cache_pkg::*;

	// One valid bit per slot.
	logic [DP-1:0] valid_q;

	// Stored line addresses.
	line_addr_t addr_q [DP];

	// Clear and set may hit two different slots in one cycle.
	// Set is applied last, so it would win on the same slot.
	always_ff @(posedge CLK or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_q <= '0;
		end else begin
			if (clr_en_i) begin
				valid_q[clr_idx_i] <= 1'b0;
			end
			if (wr_en_i) begin
				valid_q[wr_idx_i] <= 1'b1;
			end
		end
	end

	// Address is only meaningful while its valid bit is set.
	always_ff @(posedge CLK) begin
		if (wr_en_i) begin
			addr_q[wr_idx_i] <= wr_addr_i;
		end
	end

	assign valid_o = valid_q;

	// Every slot is visible for the duplicate compare.
	always_comb begin
		for (int i = 0; i < DP; i++) begin
			addrs_o[i] = addr_q[i];
		end
	end

endmodule

/* hdl/dirty_block.sv */
module dirty_block #(
	parameter int DP = 16
) (
	input  logic                  CLK,
	input  logic                  rst_n_i,
	input  logic                  push_i,
	input  cache_pkg::line_addr_t addr_i,
	input  logic                  pop_i,
	output cache_pkg::line_addr_t addr_o,
	output logic                  match_o,
	output cache_pkg::status_t    status_o
);

	import cache_pkg::*;

	localparam int CW = $clog2(DP);

	logic [DP-1:0]    valid;
	line_addr_t       slot_addr [DP];
	logic [DP-1:0]    hit;
	logic [CW-1:0]    free_idx;
	logic [CW-1:0]    head_idx;
	logic             free_none;
	logic             head_none;
	logic             wr_en;
	logic             clr_en;
	logic [OCC_W-1:0] occ;

	// Compare the incoming address against every live slot.
	always_comb begin
		for (int i = 0; i < DP; i++) begin
			hit[i] = valid[i] & (slot_addr[i] == addr_i);
		end
	end

	assign match_o = |hit;

	// A recorded line takes no second slot.
	// Nothing is written when no slot is free.
	assign wr_en = push_i & ~match_o & ~free_none;

	// Pop drops the head slot, if there is one.
	assign clr_en = pop_i & ~head_none;

	slot_store #(.DP(DP)) u_store (
		.CLK      (CLK),
		.rst_n_i  (rst_n_i),
		.wr_en_i  (wr_en),
		.wr_idx_i (free_idx),
		.wr_addr_i(addr_i),
		.clr_en_i (clr_en),
		.clr_idx_i(head_idx),
		.valid_o  (valid),
		.addrs_o  (slot_addr)
	);

	// Lowest free slot receives the next new address.
	prio_enc #(.DP(DP)) u_free_enc (
		.in_i  (~valid),
		.pos_o (free_idx),
		.none_o(free_none)
	);

	// Lowest occupied slot is the next one to drain.
	prio_enc #(.DP(DP)) u_head_enc (
		.in_i  (valid),
		.pos_o (head_idx),
		.none_o(head_none)
	);

	assign addr_o = slot_addr[head_idx];

	// Population count of the valid bits.
	always_comb begin
		occ = '0;
		for (int i = 0; i < DP; i++) begin
			occ = occ + OCC_W'(valid[i]);
		end
	end

	assign status_o = '{empty: head_none, full: free_none, occupancy: occ};

endmodule

/* hdl/axil_regs.sv */
module axil_regs (
	input  logic                              CLK,
	input  logic                              rst_n_i,
	input  axil_pkg::axil_req_t               axil_req_i,
	output axil_pkg::axil_rsp_t               axil_rsp_o,
	input  logic                              busy_i,
	input  cache_pkg::status_t                status_i,
	input  logic [cache_pkg::WB_CNT_W-1:0]    wb_count_i,
	output logic                              flush_start_o,
	output logic                              cnt_clear_o
);

	import axil_pkg::*;

	logic               wr_take;
	logic               rd_take;
	logic               wr_hit;
	logic               rd_hit;
	logic [AXIL_DW-1:0] rd_word;
	logic               bvalid_q;
	logic               rvalid_q;
	logic [1:0]         bresp_q;
	logic [1:0]         rresp_q;
	logic [AXIL_DW-1:0] rdata_q;

	// Address and data are taken together, one write in flight.
	assign wr_take = axil_req_i.awvalid & axil_req_i.wvalid & ~bvalid_q;

	// A read waits until the previous response is gone.
	assign rd_take = axil_req_i.arvalid & ~rvalid_q;

	// Mapped write offsets.
	// STATUS is read-only, a write there is accepted and ignored.
	assign wr_hit = (axil_req_i.awaddr == REG_CTRL) |
		(axil_req_i.awaddr == REG_STATUS) |
		(axil_req_i.awaddr == REG_WBCNT);

	// Side effects of a write, one cycle each.
	assign flush_start_o = wr_take & (axil_req_i.awaddr == REG_CTRL) & axil_req_i.wdata[0];
	assign cnt_clear_o   = wr_take & (axil_req_i.awaddr == REG_WBCNT);

	// Read decode.
	always_comb begin
		rd_hit  = 1'b1;
		rd_word = '0;
		case (axil_req_i.araddr)
			REG_CTRL: rd_word = {{(AXIL_DW - 1){1'b0}}, busy_i};
			REG_STATUS: rd_word = {16'h0, status_i.occupancy, 6'h0, status_i.full, status_i.empty};
			REG_WBCNT: rd_word = wb_count_i;
			default: rd_hit = 1'b0;
		endcase
	end

	// Response valids.
	always_ff @(posedge CLK or negedge rst_n_i) begin
		if (!rst_n_i) begin
			bvalid_q <= 1'b0;
			rvalid_q <= 1'b0;
		end else begin
			if (wr_take) begin
				bvalid_q <= 1'b1;
			end else if (axil_req_i.bready) begin
				bvalid_q <= 1'b0;
			end
			if (rd_take) begin
				rvalid_q <= 1'b1;
			end else if (axil_req_i.rready) begin
				rvalid_q <= 1'b0;
			end
		end
	end

	// Response payload, held until the handshake.
	always_ff @(posedge CLK) begin
		if (wr_take) begin
			bresp_q <= wr_hit ? RESP_OKAY : RESP_SLVERR;
		end
		if (rd_take) begin
			rdata_q <= rd_word;
			rresp_q <= rd_hit ? RESP_OKAY : RESP_SLVERR;
		end
	end

	// Ready strobes only in the cycle a request is taken.
	always_comb begin
		axil_rsp_o.awready = wr_take;
		axil_rsp_o.wready  = wr_take;
		axil_rsp_o.bvalid  = bvalid_q;
		axil_rsp_o.bresp   = bresp_q;
		axil_rsp_o.arready = rd_take;
		axil_rsp_o.rvalid  = rvalid_q;
		axil_rsp_o.rdata   = rdata_q;
		axil_rsp_o.rresp   = rresp_q;
	end

endmodule

/* hdl/flush_ctrl.sv */
module flush_ctrl (
	input  logic                           CLK,
	input  logic                           rst_n_i,
	input  logic                           mark_valid_i,
	output logic                           mark_ready_o,
	input  logic                           flush_start_i,
	input  logic                           cnt_clear_i,
	input  logic                           match_i,
	input  cache_pkg::status_t             status_i,
	input  cache_pkg::line_addr_t          buf_addr_i,
	output logic                           push_o,
	output logic                           pop_o,
	output logic                           wb_valid_o,
	input  logic                           wb_ready_i,
	output cache_pkg::wb_req_t             wb_o,
	output logic                           busy_o,
	output logic [cache_pkg::WB_CNT_W-1:0] wb_count_o
);

	import cache_pkg::*;

	typedef enum logic {
		ST_IDLE,
		ST_DRAIN
	} state_t;

	state_t              state_q;
	state_t              state_d;
	logic [WB_CNT_W-1:0] cnt_q;

	// A start while draining is ignored.
	// Draining ends one cycle after the buffer is seen empty.
	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				if (flush_start_i) begin
					state_d = ST_DRAIN;
				end
			end
			ST_DRAIN: begin
				if (status_i.empty) begin
					state_d = ST_IDLE;
				end
			end
			default: state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge CLK or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= ST_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	assign busy_o = (state_q == ST_DRAIN);

	// Marks stall only on a full buffer with a new line.
	assign mark_ready_o = ~status_i.full | match_i;
	assign push_o       = mark_valid_i & mark_ready_o;

	// Head slot is offered while draining.
	assign wb_valid_o = busy_o & ~status_i.empty;
	assign wb_o       = '{addr: buf_addr_i};

	// Handshake pops the head.
	assign pop_o = wb_valid_o & wb_ready_i;

	// Write-back counter, sticks at all ones.
	// Clear takes priority over a handshake.
	always_ff @(posedge CLK or negedge rst_n_i) begin
		if (!rst_n_i) begin
			cnt_q <= '0;
		end else if (cnt_clear_i) begin
			cnt_q <= '0;
		end else if (pop_o && (cnt_q != '1)) begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	assign wb_count_o = cnt_q;

endmodule

/* hdl/dirty_tracker_top.sv */
module dirty_tracker_top #(
	parameter int DP = 16
) (
	input  logic                  CLK,
	input  logic                  rst_n_i,
	input  axil_pkg::axil_req_t   axil_req_i,
	output axil_pkg::axil_rsp_t   axil_rsp_o,
	input  logic                  mark_valid_i,
	input  cache_pkg::line_addr_t mark_addr_i,
	output logic                  mark_ready_o,
	output logic                  wb_valid_o,
	input  logic                  wb_ready_i,
	output cache_pkg::wb_req_t    wb_o
);

	import cache_pkg::*;

	logic                match;
	status_t             status;
	line_addr_t          buf_addr;
	logic                push;
	logic                pop;
	logic                busy;
	logic [WB_CNT_W-1:0] wb_count;
	logic                flush_start;
	logic                cnt_clear;

	// Software side.
	axil_regs u_regs (
		.CLK          (CLK),
		.rst_n_i      (rst_n_i),
		.axil_req_i   (axil_req_i),
		.axil_rsp_o   (axil_rsp_o),
		.busy_i       (busy),
		.status_i     (status),
		.wb_count_i   (wb_count),
		.flush_start_o(flush_start),
		.cnt_clear_o  (cnt_clear)
	);

	// Stream handshakes and flush sequencing.
	flush_ctrl u_ctrl (
		.CLK          (CLK),
		.rst_n_i      (rst_n_i),
		.mark_valid_i (mark_valid_i),
		.mark_ready_o (mark_ready_o),
		.flush_start_i(flush_start),
		.cnt_clear_i  (cnt_clear),
		.match_i      (match),
		.status_i     (status),
		.buf_addr_i   (buf_addr),
		.push_o       (push),
		.pop_o        (pop),
		.wb_valid_o   (wb_valid_o),
		.wb_ready_i   (wb_ready_i),
		.wb_o         (wb_o),
		.busy_o       (busy),
		.wb_count_o   (wb_count)
	);

	// Dirty line record.
	dirty_block #(.DP(DP)) u_dirty (
		.CLK     (CLK),
		.rst_n_i (rst_n_i),
		.push_i  (push),
		.addr_i  (mark_addr_i),
		.pop_i   (pop),
		.addr_o  (buf_addr),
		.match_o (match),
		.status_o(status)
	);

endmodule

/* testbench/tb_dirty_tracker.sv */
module tb_dirty_tracker;

	timeunit 1ns;
	timeprecision 1ps;

	import cache_pkg::*;
	import axil_pkg::*;

	localparam int DP = 16;
	localparam logic [31:0] SEED = 32'h84e2;
	// About 80 marks and register accesses, 64 cycles each, plus slack.
	localparam int N_OPS = 80;
	localparam int LIMIT_CYCLES = N_OPS * 64 + 500;

	logic       CLK;
	logic       rst_n;
	axil_req_t  axil_req;
	axil_rsp_t  axil_rsp;
	logic       mark_valid;
	line_addr_t mark_addr;
	logic       mark_ready;
	logic       wb_valid;
	logic       wb_ready;
	wb_req_t    wb;

	// Slot model, handshake count and logs of the current phase.
	logic        ref_valid [DP];
	line_addr_t  ref_addr [DP];
	int          hs_count;
	line_addr_t  wb_log [$];
	line_addr_t  marked [$];
	int          value_errs;
	int          other_errs;
	logic [31:0] stim_state;
	logic [31:0] bp_state;
	// Write-back offered and not taken on the previous cycle.
	logic        wb_held;

	dirty_tracker_top #(.DP(DP)) u_dut (
		.CLK         (CLK),
		.rst_n_i     (rst_n),
		.axil_req_i  (axil_req),
		.axil_rsp_o  (axil_rsp),
		.mark_valid_i(mark_valid),
		.mark_addr_i (mark_addr),
		.mark_ready_o(mark_ready),
		.wb_valid_o  (wb_valid),
		.wb_ready_i  (wb_ready),
		.wb_o        (wb)
	);

	always #4 CLK = ~CLK;

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Lowest slot whose valid bit equals want, or -1.
	function automatic int lowest_slot(input logic want);
		for (int k = 0; k < DP; k++) begin
			if (ref_valid[k] == want) begin
				return k;
			end
		end
		return -1;
	endfunction

	// Slot that already records a, or -1.
	function automatic int find_addr(input line_addr_t a);
		for (int k = 0; k < DP; k++) begin
			if (ref_valid[k] && ref_addr[k] == a) begin
				return k;
			end
		end
		return -1;
	endfunction

	// STATUS as the register map lays it out for the model contents.
	function automatic logic [31:0] status_word();
		int occ;
		occ = 0;
		for (int k = 0; k < DP; k++) begin
			if (ref_valid[k]) begin
				occ++;
			end
		end
		return {16'h0, 8'(occ), 6'h0, occ == DP, occ == 0};
	endfunction

	function automatic int times_in_log(input line_addr_t a);
		int n;
		n = 0;
		foreach (wb_log[k]) begin
			if (wb_log[k] == a) begin
				n++;
			end
		end
		return n;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		$display("FAILED %s: expected 0x%08h, got 0x%08h at %0t", name, exp, act, $time);
		value_errs++;
	endtask

	task automatic report_problem(input string what);
		$display("Error at %0t: %s", $time, what);
		other_errs++;
	endtask

	// Model update and write-back compare, sampled at the falling edge.
	always @(negedge CLK) begin
		int head;
		int free_slot;
		int hit;
		if (rst_n) begin
			head = lowest_slot(1'b1);
			free_slot = lowest_slot(1'b0);
			hit = find_addr(mark_addr);
			// Stall only when no slot is free and the line is new.
			if (mark_valid && (mark_ready !== (free_slot >= 0 || hit >= 0))) begin
				report_mismatch("mark_ready_o", free_slot >= 0 || hit >= 0, mark_ready);
			end
			// Nothing is offered from an empty buffer.
			if (head < 0 && wb_valid !== 1'b0) begin
				report_mismatch("wb_valid_o", 32'h0, wb_valid);
			end
			// An offer stays up until it is taken.
			if (wb_held && wb_valid !== 1'b1) begin
				report_mismatch("wb_valid_o", 32'h1, wb_valid);
			end
			if (wb_valid && wb_ready) begin
				if (head < 0) begin
					report_problem("write-back handshake while no line is recorded");
				end else begin
					if (wb.addr !== ref_addr[head]) begin
						report_mismatch("wb_o.addr", ref_addr[head], wb.addr);
					end
					wb_log.push_back(wb.addr);
					hs_count++;
				end
			end
			wb_held = wb_valid && !wb_ready;
			if (mark_valid && mark_ready) begin
				if (marked.size() == 0 || !(mark_addr inside {marked})) begin
					marked.push_back(mark_addr);
				end
				if (hit < 0 && free_slot >= 0) begin
					ref_valid[free_slot] = 1'b1;
					ref_addr[free_slot] = mark_addr;
				end
			end
			// Pop uses the head seen before this cycle's push.
			if (wb_valid && wb_ready && head >= 0) begin
				ref_valid[head] = 1'b0;
			end
		end
	end

	// Random back-pressure on the write-back stream.
	always @(posedge CLK) begin
		bp_state = lcg_step(bp_state);
		wb_ready <= bp_state[22];
	end

	task automatic send_mark(input line_addr_t a);
		@(posedge CLK);
		mark_valid <= 1'b1;
		mark_addr <= a;
		@(negedge CLK);
		while (!mark_ready) @(negedge CLK);
		@(posedge CLK);
		mark_valid <= 1'b0;
	endtask

	// New line offered to a full buffer, then withdrawn.
	task automatic offer_blocked_mark(input line_addr_t a);
		@(posedge CLK);
		mark_valid <= 1'b1;
		mark_addr <= a;
		@(negedge CLK);
		if (mark_ready !== 1'b0) begin
			report_mismatch("mark_ready_o", 32'h0, mark_ready);
		end
		@(posedge CLK);
		mark_valid <= 1'b0;
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		@(posedge CLK);
		axil_req.awvalid <= 1'b1;
		axil_req.awaddr <= addr;
		axil_req.wvalid <= 1'b1;
		axil_req.wdata <= data;
		axil_req.bready <= 1'b1;
		@(negedge CLK);
		while (!axil_rsp.awready) @(negedge CLK);
		@(posedge CLK);
		axil_req.awvalid <= 1'b0;
		axil_req.wvalid <= 1'b0;
		@(negedge CLK);
		while (!axil_rsp.bvalid) @(negedge CLK);
		resp = axil_rsp.bresp;
		@(posedge CLK);
		axil_req.bready <= 1'b0;
	endtask

	task automatic read_reg(input logic [7:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		@(posedge CLK);
		axil_req.arvalid <= 1'b1;
		axil_req.araddr <= addr;
		axil_req.rready <= 1'b1;
		@(negedge CLK);
		while (!axil_rsp.arready) @(negedge CLK);
		@(posedge CLK);
		axil_req.arvalid <= 1'b0;
		@(negedge CLK);
		while (!axil_rsp.rvalid) @(negedge CLK);
		data = axil_rsp.rdata;
		resp = axil_rsp.rresp;
		@(posedge CLK);
		axil_req.rready <= 1'b0;
	endtask

	// Poll CTRL until busy drops.
	task automatic wait_idle();
		logic [31:0] rd;
		logic [1:0]  rsp;
		int          polls;
		polls = 0;
		rd = 32'h1;
		while (rd[0] && polls < 100) begin
			read_reg(REG_CTRL, rd, rsp);
			polls++;
		end
		if (rd[0]) begin
			report_problem("flush still busy after 100 polls of CTRL");
		end
	endtask

	// Each distinct line marked in the phase is written back once.
	task automatic verify_drain();
		foreach (marked[k]) begin
			if (times_in_log(marked[k]) != 1) begin
				report_problem($sformatf("line 0x%08h written back %0d times",
					marked[k], times_in_log(marked[k])));
			end
		end
		if (wb_log.size() != marked.size()) begin
			report_mismatch("write-back total", marked.size(), wb_log.size());
		end
	endtask

	task automatic expect_reg(input logic [7:0] addr, input logic [31:0] exp,
			input string name);
		logic [31:0] rd;
		logic [1:0]  rsp;
		read_reg(addr, rd, rsp);
		if (rd !== exp) begin
			report_mismatch(name, exp, rd);
		end
		if (rsp !== RESP_OKAY) begin
			report_mismatch({name, " rresp"}, RESP_OKAY, rsp);
		end
	endtask

	initial begin
		logic [31:0] rd;
		logic [1:0]  rsp;
		CLK = 1'b0;
		rst_n = 1'b0;
		axil_req = '0;
		mark_valid = 1'b0;
		mark_addr = '0;
		wb_ready = 1'b0;
		stim_state = SEED;
		bp_state = SEED;
		hs_count = 0;
		value_errs = 0;
		other_errs = 0;
		wb_held = 1'b0;
		for (int k = 0; k < DP; k++) begin
			ref_valid[k] = 1'b0;
			ref_addr[k] = '0;
		end
		repeat (5) @(posedge CLK);
		rst_n <= 1'b1;

		// Empty right after reset.
		expect_reg(REG_STATUS, 32'h1, "STATUS");

		// Marks from a pool of ten lines, so repeats occur.
		for (int k = 0; k < 24; k++) begin
			stim_state = lcg_step(stim_state);
			send_mark(32'h400 + ((32'(stim_state[31:16]) % 32'd10) << 6));
		end
		expect_reg(REG_STATUS, status_word(), "STATUS");
		read_reg(REG_STATUS, rd, rsp);
		if (rd[15:8] != marked.size()) begin
			report_mismatch("STATUS.occupancy", marked.size(), rd[15:8]);
		end

		// Flush under back-pressure.
		write_reg(REG_CTRL, 32'h1, rsp);
		wait_idle();
		verify_drain();
		expect_reg(REG_STATUS, 32'h1, "STATUS");

		// Fill every slot.
		marked.delete();
		wb_log.delete();
		for (int k = 0; k < DP; k++) begin
			send_mark(32'h1000 + (k << 6));
		end
		expect_reg(REG_STATUS, {16'h0, 8'(DP), 6'h0, 2'b10}, "STATUS");
		offer_blocked_mark(32'h9000);
		// A recorded line still passes and takes no slot.
		send_mark(32'h1000 + (5 << 6));
		expect_reg(REG_STATUS, status_word(), "STATUS");

		// Fresh lines marked while the flush runs.
		write_reg(REG_CTRL, 32'h1, rsp);
		for (int k = 0; k < 8; k++) begin
			send_mark(32'h2000 + (k << 6));
		end
		wait_idle();
		verify_drain();
		expect_reg(REG_STATUS, 32'h1, "STATUS");

		// Write-back count and its clear.
		expect_reg(REG_WBCNT, hs_count, "WBCNT");
		write_reg(REG_WBCNT, 32'h0, rsp);
		if (rsp !== RESP_OKAY) begin
			report_mismatch("WBCNT bresp", RESP_OKAY, rsp);
		end
		hs_count = 0;
		expect_reg(REG_WBCNT, hs_count, "WBCNT");

		// Unmapped offset.
		write_reg(8'h10, 32'h1, rsp);
		if (rsp !== RESP_SLVERR) begin
			report_mismatch("bresp", RESP_SLVERR, rsp);
		end
		read_reg(8'h10, rd, rsp);
		if (rsp !== RESP_SLVERR) begin
			report_mismatch("rresp", RESP_SLVERR, rsp);
		end
		if (rd !== 32'h0) begin
			report_mismatch("rdata", 32'h0, rd);
		end
		expect_reg(REG_CTRL, 32'h0, "CTRL");

		repeat (4) @(posedge CLK);
		$display("Value mismatches: %0d, other failures: %0d", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	// Watchdog.
	initial begin
		repeat (LIMIT_CYCLES) @(posedge CLK);
		$display("Error: run did not finish within %0d cycles", LIMIT_CYCLES);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

/* sim.f */
hdl/cache_pkg.sv
hdl/axil_pkg.sv
hdl/prio_enc.sv
hdl/slot_store.sv
hdl/dirty_block.sv
hdl/axil_regs.sv
hdl/flush_ctrl.sv
hdl/dirty_tracker_top.sv
testbench/tb_dirty_tracker.sv

/* run.sh */
#!/bin/sh
# Build and run the dirty tracker testbench with Verilator.
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_dirty_tracker \
	-f sim.f --Mdir obj_dir -o tb_dirty_tracker
./obj_dir/tb_dirty_tracker > sim.log 2>&1 || true
cat sim.log
if grep -q "^=== PASS ===$" sim.log; then
	exit 0
fi
exit 1
